/* hw/trap_consts.svh */
// RV32 machine-mode constants only; CSR addresses and bit positions follow the privileged spec
`ifndef TRAP_CONSTS_SVH
`define TRAP_CONSTS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define XLEN        32
`define CSR_ADDR_W  12
`define IRQ_ID_W    8

// --------------------------------------------------
// machine CSR addresses
// --------------------------------------------------
`define CSR_MSTATUS 12'h300
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MTVAL   12'h343

// mstatus bits
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

// mie bits
`define MIE_MSIE 3
`define MIE_MTIE 7
`define MIE_MEIE 11

// --------------------------------------------------
// mcause codes
// --------------------------------------------------
`define CAUSE_FETCH_MISALIGN 32'd0
`define CAUSE_ILLEGAL        32'd2
`define CAUSE_BREAK          32'd3
`define CAUSE_LOAD_MISALIGN  32'd4
`define CAUSE_STORE_MISALIGN 32'd6
`define CAUSE_ECALL          32'd11
`define CAUSE_SOFT_IRQ       32'd3
`define CAUSE_TIMER_IRQ      32'd7
`define CAUSE_EXT_IRQ_BASE   32'd16
`define CAUSE_INT_BIT        31   // interrupt flag in mcause

`endif

/* hw/trap_pkg.sv */
// shared types for the trap controller; widths are fixed by the RV32 CSR layout
`default_nettype none

`include "trap_consts.svh"

package trap_pkg;

    // data, pc and cause words
    typedef logic [`XLEN-1:0] word_t;

    // csr address as seen by the csr file write port
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // external interrupt id from the platform controller
    typedef logic [`IRQ_ID_W-1:0] irq_id_t;

    // --------------------------------------------------
    // sequencer states, one-hot
    // --------------------------------------------------
    typedef enum logic [5:0] {
        IDLE    = 6'b000001,
        MEPC    = 6'b000010,   // return pc
        MSTATUS = 6'b000100,   // mie cleared
        MTVAL   = 6'b001000,   // illegal instruction only
        MCAUSE  = 6'b010000,   // last write, redirect
        MRET    = 6'b100000    // mstatus restore, back to mepc
    } seq_state_e;

endpackage

`default_nettype wire

/* hw/trap_arbiter.sv */
// accepts one request only while the sequencer is idle; busy-time requests are dropped
`timescale 1ns/1ps
`default_nettype none

`include "trap_consts.svh"

module trap_arbiter (
    input  wire                clk,
    input  wire                rst_n,
    // exception strobes, one cycle each
    input  wire                ecall_i,
    input  wire                ebreak_i,
    input  wire                illegal_inst_i,
    input  wire                misaligned_load_i,
    input  wire                misaligned_store_i,
    input  wire                misaligned_fetch_i,
    input  wire                mret_i,
    // data for the strobes
    input  trap_pkg::word_t    illegal_pc_i,
    input  trap_pkg::word_t    illegal_val_i,
    input  trap_pkg::word_t    ex_pc_i,
    input  trap_pkg::word_t    ex_val_i,
    input  trap_pkg::word_t    inst_addr_i,
    input  wire                jump_flag_i,
    input  trap_pkg::word_t    jump_addr_i,
    // interrupt levels
    input  wire                ext_irq_i,
    input  trap_pkg::irq_id_t  irq_id_i,
    input  wire                timer_irq_i,
    input  wire                soft_irq_i,
    input  wire                atom_busy_i,
    // current csr values
    input  trap_pkg::word_t    csr_mstatus_i,
    input  trap_pkg::word_t    csr_mie_i,
    input  wire                seq_idle_i,
    // to the sequencer
    output logic               trap_take_o,
    output logic               mret_take_o,
    output trap_pkg::word_t    mepc_val_o,
    output trap_pkg::word_t    mtval_val_o,
    output trap_pkg::word_t    cause_val_o,
    output logic               has_mtval_o,
    output logic               is_irq_o,
    output logic               stall_o
);

    // --------------------------------------------------
    // interrupt gating
    // --------------------------------------------------
    logic glb_ie;
    logic soft_en;
    logic timer_en;
    logic ext_en;
    logic irq_pend;
    logic exc_any;
    logic trap_req;

    assign glb_ie   = csr_mstatus_i[`MSTATUS_MIE];
    assign soft_en  = soft_irq_i  & csr_mie_i[`MIE_MSIE] & glb_ie;
    assign timer_en = timer_irq_i & csr_mie_i[`MIE_MTIE] & glb_ie;
    assign ext_en   = ext_irq_i   & csr_mie_i[`MIE_MEIE] & glb_ie;
    assign irq_pend = soft_en | timer_en | ext_en;

    assign exc_any = ecall_i | ebreak_i | illegal_inst_i | misaligned_load_i
                   | misaligned_store_i | misaligned_fetch_i;
    assign trap_req = exc_any | irq_pend;

    assign trap_take_o = trap_req & seq_idle_i & ~atom_busy_i;
    assign mret_take_o = mret_i & seq_idle_i & ~trap_take_o;
    assign stall_o     = trap_req & atom_busy_i;   // hold the core until the atomic op ends

    // --------------------------------------------------
    // cause priority and captured values
    // --------------------------------------------------
    trap_pkg::word_t cause_nxt;
    trap_pkg::word_t mepc_nxt;
    trap_pkg::word_t mtval_nxt;
    logic            has_mtval_nxt;

    always_comb begin
        has_mtval_nxt = 1'b0;
        if (ecall_i)                 cause_nxt = `CAUSE_ECALL;
        else if (ebreak_i)           cause_nxt = `CAUSE_BREAK;
        else if (misaligned_fetch_i) cause_nxt = `CAUSE_FETCH_MISALIGN;
        else if (misaligned_load_i)  cause_nxt = `CAUSE_LOAD_MISALIGN;
        else if (misaligned_store_i) cause_nxt = `CAUSE_STORE_MISALIGN;
        else if (illegal_inst_i) begin
            cause_nxt     = `CAUSE_ILLEGAL;
            has_mtval_nxt = 1'b1;   // only illegal writes mtval
        end else begin
            // interrupts rank below every exception
            if (soft_en)       cause_nxt = `CAUSE_SOFT_IRQ;
            else if (timer_en) cause_nxt = `CAUSE_TIMER_IRQ;
            else               cause_nxt = `CAUSE_EXT_IRQ_BASE + trap_pkg::word_t'(irq_id_i);
            cause_nxt[`CAUSE_INT_BIT] = 1'b1;
        end
    end

    always_comb begin
        if (misaligned_fetch_i || misaligned_load_i || misaligned_store_i)
            mepc_nxt = ex_pc_i;
        else if (jump_flag_i)
            mepc_nxt = jump_addr_i - 32'd4;
        else if (illegal_inst_i)
            mepc_nxt = illegal_pc_i;
        else if (ecall_i || ebreak_i)
            mepc_nxt = inst_addr_i;
        else
            mepc_nxt = inst_addr_i + 32'd4;   // interrupt, resume after current inst
    end

    always_comb begin
        if (misaligned_fetch_i)                          mtval_nxt = '0;
        else if (misaligned_load_i || misaligned_store_i) mtval_nxt = ex_val_i;
        else if (jump_flag_i)                            mtval_nxt = '0;
        else if (illegal_inst_i)                         mtval_nxt = illegal_val_i;
        else                                             mtval_nxt = '0;
    end

    // payload, held for the whole sequence
    always_ff @(posedge clk) begin
        if (trap_take_o) begin
            cause_val_o <= cause_nxt;
            mepc_val_o  <= mepc_nxt;
            mtval_val_o <= mtval_nxt;
        end
    end

    // flags captured at the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            has_mtval_o <= 1'b0;
            is_irq_o    <= 1'b0;
        end else if (trap_take_o) begin
            has_mtval_o <= has_mtval_nxt;
            is_irq_o    <= ~exc_any;
        end
    end

    // the sequencer must never see two takes or a take while busy
    a_take_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_take_o && mret_take_o));
    a_take_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (trap_take_o || mret_take_o) |-> seq_idle_i);

endmodule

`default_nettype wire

/* hw/csr_write_seq.sv */
// csr_mstatus_i, csr_mtvec_i and csr_mepc_i must stay stable while a sequence runs
`timescale 1ns/1ps
`default_nettype none

`include "trap_consts.svh"

module csr_write_seq (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 trap_take_i,
    input  wire                 mret_take_i,
    input  trap_pkg::word_t     mepc_val_i,
    input  trap_pkg::word_t     mtval_val_i,
    input  trap_pkg::word_t     cause_val_i,
    input  wire                 has_mtval_i,
    input  wire                 is_irq_i,
    input  trap_pkg::word_t     csr_mstatus_i,
    input  trap_pkg::word_t     csr_mtvec_i,
    input  trap_pkg::word_t     csr_mepc_i,
    output logic                seq_idle_o,
    output logic                flush_o,
    output logic                we_o,
    output trap_pkg::csr_addr_t waddr_o,
    output trap_pkg::word_t     wdata_o,
    output logic                int_assert_o,
    output trap_pkg::word_t     int_addr_o
);

    trap_pkg::seq_state_e state;

    // --------------------------------------------------
    // state transitions
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= trap_pkg::IDLE;
        end else begin
            case (state)
                trap_pkg::IDLE: begin
                    if (trap_take_i)      state <= trap_pkg::MEPC;
                    else if (mret_take_i) state <= trap_pkg::MRET;
                end
                trap_pkg::MEPC:    state <= trap_pkg::MSTATUS;
                trap_pkg::MSTATUS: state <= has_mtval_i ? trap_pkg::MTVAL : trap_pkg::MCAUSE;
                trap_pkg::MTVAL:   state <= trap_pkg::MCAUSE;
                default:           state <= trap_pkg::IDLE;   // MCAUSE, MRET
            endcase
        end
    end

    // idle only once the last write has left the port
    assign seq_idle_o = (state == trap_pkg::IDLE) && !we_o;
    assign flush_o    = (state != trap_pkg::IDLE) || we_o;

    // --------------------------------------------------
    // mstatus edits and redirect target
    // --------------------------------------------------
    trap_pkg::word_t mstatus_trap;
    trap_pkg::word_t mstatus_mret;
    trap_pkg::word_t vec_addr;

    always_comb begin
        mstatus_trap = csr_mstatus_i;
        mstatus_trap[`MSTATUS_MIE] = 1'b0;   // interrupts off in the handler

        mstatus_mret = csr_mstatus_i;
        mstatus_mret[`MSTATUS_MIE]  = csr_mstatus_i[`MSTATUS_MPIE];
        mstatus_mret[`MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        if (is_irq_i && csr_mtvec_i[0]) begin
            // vectored: base + 4 * cause[3:0]
            vec_addr = {csr_mtvec_i[`XLEN-1:2], 2'b00}
                     + {{(`XLEN-6){1'b0}}, cause_val_i[3:0], 2'b00};
        end else begin
            vec_addr = csr_mtvec_i;
        end
    end

    // --------------------------------------------------
    // write port, one write per cycle
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_o         <= 1'b0;
            waddr_o      <= '0;
            wdata_o      <= '0;
            int_assert_o <= 1'b0;
            int_addr_o   <= '0;
        end else begin
            we_o         <= 1'b0;
            int_assert_o <= 1'b0;
            case (state)
                trap_pkg::MEPC: begin
                    we_o    <= 1'b1;
                    waddr_o <= `CSR_MEPC;
                    wdata_o <= mepc_val_i;
                end
                trap_pkg::MSTATUS: begin
                    we_o    <= 1'b1;
                    waddr_o <= `CSR_MSTATUS;
                    wdata_o <= mstatus_trap;
                end
                trap_pkg::MTVAL: begin
                    we_o    <= 1'b1;
                    waddr_o <= `CSR_MTVAL;
                    wdata_o <= mtval_val_i;
                end
                trap_pkg::MCAUSE: begin
                    we_o         <= 1'b1;
                    waddr_o      <= `CSR_MCAUSE;
                    wdata_o      <= cause_val_i;
                    int_assert_o <= 1'b1;   // jump to handler
                    int_addr_o   <= vec_addr;
                end
                trap_pkg::MRET: begin
                    we_o         <= 1'b1;
                    waddr_o      <= `CSR_MSTATUS;
                    wdata_o      <= mstatus_mret;
                    int_assert_o <= 1'b1;
                    int_addr_o   <= csr_mepc_i;
                end
                default: ;
            endcase
        end
    end

    a_redirect_we: assert property (@(posedge clk) disable iff (!rst_n)
        int_assert_o |-> we_o);
    a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(state));
    // mepc, mstatus, mtval, mcause at most
    a_max_writes: assert property (@(posedge clk) disable iff (!rst_n)
        !(we_o && $past(we_o) && $past(we_o, 2) && $past(we_o, 3) && $past(we_o, 4)));

endmodule

`default_nettype wire

/* hw/trap_ctrl_top.sv */
// machine-mode trap controller; timer and software interrupts come in as plain levels
`timescale 1ns/1ps
`default_nettype none

`include "trap_consts.svh"

module trap_ctrl_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 ecall_i,
    input  wire                 ebreak_i,
    input  wire                 illegal_inst_i,
    input  wire                 misaligned_load_i,
    input  wire                 misaligned_store_i,
    input  wire                 misaligned_fetch_i,
    input  wire                 mret_i,
    input  trap_pkg::word_t     illegal_pc_i,
    input  trap_pkg::word_t     illegal_val_i,
    input  trap_pkg::word_t     ex_pc_i,
    input  trap_pkg::word_t     ex_val_i,
    input  trap_pkg::word_t     inst_addr_i,
    input  wire                 jump_flag_i,
    input  trap_pkg::word_t     jump_addr_i,
    input  wire                 ext_irq_i,
    input  trap_pkg::irq_id_t   irq_id_i,
    input  wire                 timer_irq_i,
    input  wire                 soft_irq_i,
    input  wire                 atom_busy_i,
    input  trap_pkg::word_t     csr_mstatus_i,
    input  trap_pkg::word_t     csr_mie_i,
    input  trap_pkg::word_t     csr_mtvec_i,
    input  trap_pkg::word_t     csr_mepc_i,
    output logic                flush_o,
    output logic                stall_o,
    output logic                we_o,
    output trap_pkg::csr_addr_t waddr_o,
    output trap_pkg::word_t     wdata_o,
    output logic                int_assert_o,
    output trap_pkg::word_t     int_addr_o
);

    logic            trap_take;
    logic            mret_take;
    trap_pkg::word_t mepc_val;
    trap_pkg::word_t mtval_val;
    trap_pkg::word_t cause_val;
    logic            has_mtval;
    logic            is_irq;
    logic            seq_idle;
    logic            seq_flush;

    trap_arbiter u_arbiter (
        .clk                (clk),
        .rst_n              (rst_n),
        .ecall_i            (ecall_i),
        .ebreak_i           (ebreak_i),
        .illegal_inst_i     (illegal_inst_i),
        .misaligned_load_i  (misaligned_load_i),
        .misaligned_store_i (misaligned_store_i),
        .misaligned_fetch_i (misaligned_fetch_i),
        .mret_i             (mret_i),
        .illegal_pc_i       (illegal_pc_i),
        .illegal_val_i      (illegal_val_i),
        .ex_pc_i            (ex_pc_i),
        .ex_val_i           (ex_val_i),
        .inst_addr_i        (inst_addr_i),
        .jump_flag_i        (jump_flag_i),
        .jump_addr_i        (jump_addr_i),
        .ext_irq_i          (ext_irq_i),
        .irq_id_i           (irq_id_i),
        .timer_irq_i        (timer_irq_i),
        .soft_irq_i         (soft_irq_i),
        .atom_busy_i        (atom_busy_i),
        .csr_mstatus_i      (csr_mstatus_i),
        .csr_mie_i          (csr_mie_i),
        .seq_idle_i         (seq_idle),
        .trap_take_o        (trap_take),
        .mret_take_o        (mret_take),
        .mepc_val_o         (mepc_val),
        .mtval_val_o        (mtval_val),
        .cause_val_o        (cause_val),
        .has_mtval_o        (has_mtval),
        .is_irq_o           (is_irq),
        .stall_o            (stall_o)
    );

    csr_write_seq u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .trap_take_i   (trap_take),
        .mret_take_i   (mret_take),
        .mepc_val_i    (mepc_val),
        .mtval_val_i   (mtval_val),
        .cause_val_i   (cause_val),
        .has_mtval_i   (has_mtval),
        .is_irq_i      (is_irq),
        .csr_mstatus_i (csr_mstatus_i),
        .csr_mtvec_i   (csr_mtvec_i),
        .csr_mepc_i    (csr_mepc_i),
        .seq_idle_o    (seq_idle),
        .flush_o       (seq_flush),
        .we_o          (we_o),
        .waddr_o       (waddr_o),
        .wdata_o       (wdata_o),
        .int_assert_o  (int_assert_o),
        .int_addr_o    (int_addr_o)
    );

    // flush also covers the accepting cycle
    assign flush_o = seq_flush | trap_take;

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// free-running 20 ns clock; reset is held low for the first 16 rising edges, then released
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;   // 20 ns period
    end

    initial begin
        rst_n_o <= 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* bench/tb_trap_ctrl.sv */
// directed tests; the bench plays the CSR file and holds the csr inputs stable during a sequence
`timescale 1ns/1ps
`default_nettype none

`include "trap_consts.svh"

module tb_trap_ctrl;

    logic clk;
    logic rst_n;

    // DUT inputs
    logic ecall_i, ebreak_i, illegal_inst_i, mret_i;
    logic misaligned_load_i, misaligned_store_i, misaligned_fetch_i;
    logic jump_flag_i, ext_irq_i, timer_irq_i, soft_irq_i, atom_busy_i;
    trap_pkg::word_t illegal_pc_i, illegal_val_i, ex_pc_i, ex_val_i;
    trap_pkg::word_t inst_addr_i, jump_addr_i;
    trap_pkg::irq_id_t irq_id_i;
    trap_pkg::word_t csr_mstatus_i, csr_mie_i, csr_mtvec_i, csr_mepc_i;

    // DUT outputs
    logic flush_o, stall_o, we_o, int_assert_o;
    trap_pkg::csr_addr_t waddr_o;
    trap_pkg::word_t wdata_o, int_addr_o;

    // collected writes of one sequence
    int errors;
    int checks;
    trap_pkg::csr_addr_t wr_addr_q[$];
    trap_pkg::word_t     wr_data_q[$];
    int pulse_cnt;
    int pulse_idx;
    int flush_low;
    trap_pkg::word_t redirect_addr;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    trap_ctrl_top dut (
        .clk(clk), .rst_n(rst_n),
        .ecall_i(ecall_i), .ebreak_i(ebreak_i), .illegal_inst_i(illegal_inst_i),
        .misaligned_load_i(misaligned_load_i), .misaligned_store_i(misaligned_store_i),
        .misaligned_fetch_i(misaligned_fetch_i), .mret_i(mret_i),
        .illegal_pc_i(illegal_pc_i), .illegal_val_i(illegal_val_i),
        .ex_pc_i(ex_pc_i), .ex_val_i(ex_val_i), .inst_addr_i(inst_addr_i),
        .jump_flag_i(jump_flag_i), .jump_addr_i(jump_addr_i),
        .ext_irq_i(ext_irq_i), .irq_id_i(irq_id_i), .timer_irq_i(timer_irq_i),
        .soft_irq_i(soft_irq_i), .atom_busy_i(atom_busy_i),
        .csr_mstatus_i(csr_mstatus_i), .csr_mie_i(csr_mie_i),
        .csr_mtvec_i(csr_mtvec_i), .csr_mepc_i(csr_mepc_i),
        .flush_o(flush_o), .stall_o(stall_o), .we_o(we_o), .waddr_o(waddr_o),
        .wdata_o(wdata_o), .int_assert_o(int_assert_o), .int_addr_o(int_addr_o)
    );

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_word(input string what, input trap_pkg::word_t got,
                              input trap_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input trap_pkg::csr_addr_t got,
                              input trap_pkg::csr_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // redirect target from mtvec mode and cause
    function automatic trap_pkg::word_t vector_addr(input trap_pkg::word_t cause);
        if (cause[`CAUSE_INT_BIT] && csr_mtvec_i[0])
            return (csr_mtvec_i & 32'hFFFF_FFFC) + 32'd4 * (cause & 32'h0000_000F);
        return csr_mtvec_i;
    endfunction

    task automatic release_inputs();
        ecall_i            <= 1'b0;
        ebreak_i           <= 1'b0;
        illegal_inst_i     <= 1'b0;
        misaligned_load_i  <= 1'b0;
        misaligned_store_i <= 1'b0;
        misaligned_fetch_i <= 1'b0;
        mret_i             <= 1'b0;
        jump_flag_i        <= 1'b0;
        ext_irq_i          <= 1'b0;
        timer_irq_i        <= 1'b0;
        soft_irq_i         <= 1'b0;
        atom_busy_i        <= 1'b0;
    endtask

    // request was driven on the last rising edge, accepted on the next one
    task automatic accept_cycle(input logic check_flush);
        @(negedge clk);
        if (check_flush)
            check_word("flush in accepting cycle", trap_pkg::word_t'(flush_o), 32'd1);
        @(posedge clk);
        release_inputs();
    endtask

    task automatic collect_writes();
        int wait_cnt;
        wr_addr_q.delete();
        wr_data_q.delete();
        pulse_cnt     = 0;
        pulse_idx     = -1;
        flush_low     = 0;
        redirect_addr = '0;
        wait_cnt      = 0;
        @(negedge clk);
        while (!we_o && wait_cnt < 50) begin
            if (!flush_o) flush_low++;
            @(negedge clk);
            wait_cnt++;
        end
        if (!we_o) begin
            errors++;
            $display("timeout: no CSR write arrived within 50 cycles at %0t", $time);
            return;
        end
        wait_cnt = 0;
        while (we_o && wait_cnt < 50) begin
            if (!flush_o) flush_low++;
            if (int_assert_o) begin
                pulse_cnt++;
                pulse_idx     = wr_addr_q.size();
                redirect_addr = int_addr_o;
            end
            wr_addr_q.push_back(waddr_o);
            wr_data_q.push_back(wdata_o);
            @(negedge clk);
            wait_cnt++;
        end
        if (we_o) begin
            errors++;
            $display("timeout: CSR write port stayed busy for 50 cycles at %0t", $time);
        end
    endtask

    task automatic expect_quiet(input int cycles, input logic exp_stall);
        int wr_seen;
        int stall_bad;
        wr_seen   = 0;
        stall_bad = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (we_o || int_assert_o) wr_seen++;
            if (stall_o !== exp_stall) stall_bad++;
        end
        check_word("writes while held off", wr_seen, 32'd0);
        check_word("cycles with wrong stall", stall_bad, 32'd0);
    endtask

    // expected trap sequence: mepc, mstatus, optional mtval, mcause
    task automatic compare_trap_writes(input trap_pkg::word_t exp_mepc,
                                       input logic exp_has_mtval,
                                       input trap_pkg::word_t exp_mtval,
                                       input trap_pkg::word_t exp_cause);
        trap_pkg::word_t exp_mstatus;
        int n_exp;
        int last;
        exp_mstatus = csr_mstatus_i;
        exp_mstatus[`MSTATUS_MIE] = 1'b0;
        n_exp = exp_has_mtval ? 4 : 3;
        last  = n_exp - 1;
        collect_writes();
        check_word("write count", wr_addr_q.size(), n_exp);
        if (wr_addr_q.size() == n_exp) begin
            check_addr("1st write address", wr_addr_q[0], `CSR_MEPC);
            check_word("mepc", wr_data_q[0], exp_mepc);
            check_addr("2nd write address", wr_addr_q[1], `CSR_MSTATUS);
            check_word("mstatus", wr_data_q[1], exp_mstatus);
            if (exp_has_mtval) begin
                check_addr("3rd write address", wr_addr_q[2], `CSR_MTVAL);
                check_word("mtval", wr_data_q[2], exp_mtval);
            end
            check_addr("last write address", wr_addr_q[last], `CSR_MCAUSE);
            check_word("mcause", wr_data_q[last], exp_cause);
        end
        check_word("redirect pulses", pulse_cnt, 32'd1);
        check_word("redirect write index", pulse_idx, last);
        check_word("redirect address", redirect_addr, vector_addr(exp_cause));
        check_word("cycles without flush", flush_low, 32'd0);
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "FAIL",
                 errors - err0);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic reset_outputs();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_word("we_o after reset", trap_pkg::word_t'(we_o), 32'd0);
        check_word("int_assert_o after reset", trap_pkg::word_t'(int_assert_o), 32'd0);
        check_word("flush_o after reset", trap_pkg::word_t'(flush_o), 32'd0);
        check_word("stall_o after reset", trap_pkg::word_t'(stall_o), 32'd0);
        check_addr("waddr_o after reset", waddr_o, '0);
        check_word("wdata_o after reset", wdata_o, '0);
        check_word("int_addr_o after reset", int_addr_o, '0);
        report_test("reset", err0);
    endtask

    task automatic ecall_trap();
        int err0;
        trap_pkg::word_t pc;
        err0 = errors;
        pc   = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        ecall_i     <= 1'b1;
        inst_addr_i <= pc;
        accept_cycle(1'b1);
        compare_trap_writes(pc, 1'b0, '0, `CAUSE_ECALL);
        report_test("ecall", err0);
    endtask

    task automatic illegal_trap();
        int err0;
        trap_pkg::word_t pc;
        trap_pkg::word_t val;
        trap_pkg::word_t jmp;
        err0 = errors;
        pc   = $urandom & 32'hFFFF_FFFC;
        val  = $urandom;
        jmp  = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        illegal_inst_i <= 1'b1;
        illegal_pc_i   <= pc;
        illegal_val_i  <= val;
        accept_cycle(1'b1);
        compare_trap_writes(pc, 1'b1, val, `CAUSE_ILLEGAL);
        // taken jump in flight, mepc from the jump target
        @(posedge clk);
        illegal_inst_i <= 1'b1;
        jump_flag_i    <= 1'b1;
        jump_addr_i    <= jmp;
        illegal_val_i  <= $urandom;
        accept_cycle(1'b1);
        compare_trap_writes(jmp - 32'd4, 1'b1, '0, `CAUSE_ILLEGAL);
        report_test("illegal", err0);
    endtask

    task automatic misaligned_traps();
        int err0;
        int k;
        trap_pkg::word_t pc;
        trap_pkg::word_t exp_cause;
        err0 = errors;
        for (k = 0; k < 3; k++) begin
            pc = $urandom & 32'hFFFF_FFFE;
            @(posedge clk);
            ex_pc_i  <= pc;
            ex_val_i <= $urandom;
            case (k)
                0:       misaligned_load_i  <= 1'b1;
                1:       misaligned_store_i <= 1'b1;
                default: misaligned_fetch_i <= 1'b1;
            endcase
            accept_cycle(1'b1);
            case (k)
                0:       exp_cause = `CAUSE_LOAD_MISALIGN;
                1:       exp_cause = `CAUSE_STORE_MISALIGN;
                default: exp_cause = `CAUSE_FETCH_MISALIGN;
            endcase
            compare_trap_writes(pc, 1'b0, '0, exp_cause);
        end
        // ecall outranks the load, mepc still from ex_pc
        pc = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        ecall_i           <= 1'b1;
        misaligned_load_i <= 1'b1;
        ex_pc_i           <= pc;
        inst_addr_i       <= $urandom;
        accept_cycle(1'b1);
        compare_trap_writes(pc, 1'b0, '0, `CAUSE_ECALL);
        report_test("misaligned", err0);
    endtask

    task automatic irq_gating();
        int err0;
        trap_pkg::word_t pc;
        err0 = errors;
        pc   = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        csr_mstatus_i <= 32'h0000_0080;   // MIE clear
        csr_mie_i     <= 32'h0000_0888;
        soft_irq_i    <= 1'b1;
        expect_quiet(20, 1'b0);
        @(posedge clk);
        csr_mstatus_i <= 32'h0000_0088;
        csr_mie_i     <= 32'h0000_0800;   // only MEIE
        expect_quiet(20, 1'b0);
        // software and timer both enabled
        @(posedge clk);
        csr_mie_i   <= 32'h0000_0888;
        timer_irq_i <= 1'b1;
        inst_addr_i <= pc;
        accept_cycle(1'b1);
        compare_trap_writes(pc + 32'd4, 1'b0, '0, 32'h8000_0003);
        // held off by an atomic op
        pc = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        atom_busy_i <= 1'b1;
        timer_irq_i <= 1'b1;
        inst_addr_i <= pc;
        expect_quiet(10, 1'b1);
        @(posedge clk);
        atom_busy_i <= 1'b0;
        accept_cycle(1'b1);
        compare_trap_writes(pc + 32'd4, 1'b0, '0, 32'h8000_0007);
        report_test("irq gating", err0);
    endtask

    task automatic vectored_ext_irq();
        int err0;
        trap_pkg::word_t pc;
        trap_pkg::word_t mtvec_saved;
        trap_pkg::irq_id_t id;
        trap_pkg::word_t exp_cause;
        err0        = errors;
        pc          = $urandom & 32'hFFFF_FFFC;
        id          = trap_pkg::irq_id_t'($urandom);
        mtvec_saved = csr_mtvec_i;
        @(posedge clk);
        csr_mtvec_i <= ($urandom & 32'hFFFF_FF00) | 32'h1;   // vectored mode
        ext_irq_i   <= 1'b1;
        irq_id_i    <= id;
        inst_addr_i <= pc;
        accept_cycle(1'b1);
        exp_cause = (32'd1 << `CAUSE_INT_BIT) | (`CAUSE_EXT_IRQ_BASE + trap_pkg::word_t'(id));
        compare_trap_writes(pc + 32'd4, 1'b0, '0, exp_cause);
        @(posedge clk);
        csr_mtvec_i <= mtvec_saved;
        report_test("vectored ext", err0);
    endtask

    task automatic mret_restore();
        int err0;
        int k;
        trap_pkg::word_t ms;
        trap_pkg::word_t exp_ms;
        trap_pkg::word_t mepc;
        err0 = errors;
        for (k = 0; k < 2; k++) begin
            ms = $urandom;
            ms[`MSTATUS_MPIE] = k[0];
            exp_ms = ms;
            exp_ms[`MSTATUS_MIE]  = k[0];
            exp_ms[`MSTATUS_MPIE] = 1'b1;
            mepc = $urandom & 32'hFFFF_FFFC;
            @(posedge clk);
            csr_mstatus_i <= ms;
            csr_mepc_i    <= mepc;
            mret_i        <= 1'b1;
            accept_cycle(1'b0);
            collect_writes();
            check_word("mret write count", wr_addr_q.size(), 32'd1);
            if (wr_addr_q.size() == 1) begin
                check_addr("mret write address", wr_addr_q[0], `CSR_MSTATUS);
                check_word("mret mstatus", wr_data_q[0], exp_ms);
            end
            check_word("mret redirect pulses", pulse_cnt, 32'd1);
            check_word("mret redirect address", redirect_addr, mepc);
        end
        @(posedge clk);
        csr_mstatus_i <= 32'h0000_0088;
        report_test("mret", err0);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int wait_cnt;
        errors   = 0;
        checks   = 0;
        void'($urandom(32'h6678_b4a3));
        release_inputs();
        illegal_pc_i  <= '0;
        illegal_val_i <= '0;
        ex_pc_i       <= '0;
        ex_val_i      <= '0;
        inst_addr_i   <= '0;
        jump_addr_i   <= '0;
        irq_id_i      <= '0;
        csr_mstatus_i <= 32'h0000_0088;   // MIE and MPIE set
        csr_mie_i     <= 32'h0000_0888;
        csr_mtvec_i   <= $urandom & 32'hFFFF_FFFC;   // direct mode
        csr_mepc_i    <= $urandom;
        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 100) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released within 100 cycles");
        end
        reset_outputs();
        ecall_trap();
        illegal_trap();
        misaligned_traps();
        irq_gating();
        vectored_ext_irq();
        mret_restore();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/trap_pkg.sv
hw/trap_arbiter.sv
hw/csr_write_seq.sv
hw/trap_ctrl_top.sv
bench/tb_clock_gen.sv
bench/tb_trap_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_trap_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
